// File: coreMemWrap.sv
// Tile memory wrapper
`default_nettype none
`timescale 1ns/1ns

module coreMemWrap
   import fabricPkg::*;
   import memMapPkg::*;
(
   input  logic   Clock,
   input  logic   rstN,
   input  tileIdT localTileId,
   //==================================================
   // Core instruction and data ports
   //==================================================
   input  addrT   pcQ100H,
   input  logic   readyQ101H,
   output dataT   preInstructionQ101H,
   input  addrT   dMemAddressQ103H,
   input  dataT   dMemWrDataQ103H,
   input  byteEnT dMemByteEnQ103H,
   input  logic   dMemWrEnQ103H,
   input  logic   dMemRdEnQ103H,
   output dataT   dMemRdRspQ105H,
   output logic   dMemReady,
   //==================================================
   // Fabric
   //==================================================
   input  logic   inFabricValid,
   input  addrT   inFabricAddress,
   input  dataT   inFabricData,
   input  opcodeT inFabricOpcode,
   input  tileIdT inFabricRequestorId,
   output logic   coreMemReady,
   output logic   outFabricValid,
   output addrT   outFabricAddress,
   output dataT   outFabricData,
   output opcodeT outFabricOpcode,
   output tileIdT outFabricRequestorId,
   input  logic   fabReady
);

   logic      iWrEn, dWrEn;       // Fabric writes per memory
   memIndexT  fabIndex;
   dataT      iRdData, dRdData;   // Fabric read data Q504
   logic      rspPush, reqPush, reqFull, rspArrived;
   transWordT rspWord, reqWord;

   fabricIngress u_fabricIngress (.*);

   instrFetch u_instrFetch (.*, .fabWrData (inFabricData), .fabWrEn (iWrEn),
                            .fabRdData (iRdData));

   dataAccess u_dataAccess (.*, .fabWrData (inFabricData), .fabWrEn (dWrEn),
                            .fabRdData (dRdData), .rspData (inFabricData));

   fabricEgress u_fabricEgress (.*);

endmodule

`default_nettype wire

// File: coreMemWrapTb.sv
// Tile memory wrapper testbench
`default_nettype none
`timescale 1ns/1ns

module coreMemWrapTb
   import fabricPkg::*;
   import memMapPkg::*;
();

   localparam int     TIMEOUT = 50;       // Cycles allowed per wait
   localparam tileIdT TILE_ID = 8'h05;

   //==================================================
   // DUT signals
   //==================================================
   logic      Clock = 1'b0;
   logic      rstN;
   tileIdT    localTileId;
   addrT      pcQ100H;
   logic      readyQ101H;
   dataT      preInstructionQ101H;
   addrT      dMemAddressQ103H;
   dataT      dMemWrDataQ103H;
   byteEnT    dMemByteEnQ103H;
   logic      dMemWrEnQ103H;
   logic      dMemRdEnQ103H;
   dataT      dMemRdRspQ105H;
   logic      dMemReady;
   logic      inFabricValid;
   addrT      inFabricAddress;
   dataT      inFabricData;
   opcodeT    inFabricOpcode;
   tileIdT    inFabricRequestorId;
   logic      coreMemReady;
   logic      outFabricValid;
   addrT      outFabricAddress;
   dataT      outFabricData;
   opcodeT    outFabricOpcode;
   tileIdT    outFabricRequestorId;
   logic      fabReady;
   logic [31:0] lcgState = 32'h30bbeb4b;

   always #50 Clock = ~Clock;   // 100 ns period

   coreMemWrap u_coreMemWrap (.*);

   bind fabricEgress coreMemWrap_checker u_egressChecker (.*, .rspFull (rspFifo.full));

   //==================================================
   // Helpers
   //==================================================
   function automatic dataT nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Fabric address of a word in one of our regions
   function automatic addrT fabAddr(input logic [7:0] region, input memIndexT index);
      return {TILE_ID, region, 4'h0, index, 2'b00};
   endfunction

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic checkData(input dataT act, input dataT exp, input string what);
      if (act !== exp)
         stopRun($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, what, act, exp));
   endtask

   task automatic checkWord(input transWordT act, input transWordT exp, input string what);
      if (act !== exp)
         stopRun($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, what, act, exp));
   endtask

   task automatic checkBit(input logic act, input logic exp, input string what);
      if (act !== exp)
         stopRun($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, what, act, exp));
   endtask

   // Egress assertion failures end the run
   always @(posedge Clock) begin
      if (u_coreMemWrap.u_fabricEgress.u_egressChecker.failCount != 0)
         stopRun("assertion failed in the egress checker");
   end

   // One-cycle fabric strobe
   task automatic fabricSend(input addrT addr, input dataT data, input opcodeT opc,
                             input tileIdT id);
      @(posedge Clock);
      inFabricValid       <= 1'b1;
      inFabricAddress     <= addr;
      inFabricData        <= data;
      inFabricOpcode      <= opc;
      inFabricRequestorId <= id;
      @(posedge Clock);
      inFabricValid <= 1'b0;
   endtask

   // One-cycle core data access that reads when wr is low
   task automatic coreAccess(input addrT addr, input dataT data, input byteEnT be, input logic wr);
      @(posedge Clock);
      dMemAddressQ103H <= addr;
      dMemWrDataQ103H  <= data;
      dMemByteEnQ103H  <= be;
      dMemWrEnQ103H    <= wr;
      dMemRdEnQ103H    <= !wr;
      @(posedge Clock);
      dMemWrEnQ103H <= 1'b0;
      dMemRdEnQ103H <= 1'b0;
   endtask

   // Samples at the falling edge, where the output mux is settled
   task automatic waitFabValid(output transWordT seen);
      int n;
      n = 0;
      @(negedge Clock);
      while (!outFabricValid && n < TIMEOUT) begin
         @(negedge Clock);
         n++;
      end
      if (!outFabricValid) stopRun("timeout: no transaction left on the fabric output");
      seen = {outFabricAddress, outFabricData, outFabricOpcode, outFabricRequestorId};
   endtask

   //==================================================
   // Directed tests
   //==================================================
   task automatic testInstrFetch();
      dataT words [4];
      for (int i = 0; i < 4; i++) begin
         words[i] = nextRand();
         fabricSend(fabAddr(IMEM_REGION, memIndexT'(i)), words[i], WR, 8'h00);
      end
      for (int i = 0; i < 4; i++) begin
         @(posedge Clock);
         pcQ100H <= addrT'(4 * i);
         @(posedge Clock);
         @(negedge Clock);
         checkData(preInstructionQ101H, words[i], "fetched instruction");
      end
      @(posedge Clock);
      readyQ101H <= 1'b0;   // Stall and move the PC away
      pcQ100H    <= '0;
      repeat (3) begin
         @(posedge Clock);
         @(negedge Clock);
         checkData(preInstructionQ101H, words[3], "held instruction");
      end
      @(posedge Clock);
      readyQ101H <= 1'b1;
   endtask

   task automatic testByteAccess();
      byteEnT enables [4] = '{4'hF, 4'h1, 4'h3, 4'h3};   // Word, byte, half, half
      addrT   addr;
      dataT   base, wr, merged;
      byteEnT laneEn;
      for (int off = 0; off < 4; off++) begin
         addr = {20'h0, memIndexT'(64 + off), 2'(off)};
         base = nextRand();
         wr   = nextRand();
         coreAccess({addr[31:2], 2'b00}, base, 4'hF, 1'b1);   // Known background
         coreAccess(addr, wr, enables[off], 1'b1);
         laneEn = enables[off] << off;                       // Upper lanes drop off
         merged = base;
         for (int b = off; b < 4; b++)
            if (laneEn[b]) merged[8*b +: 8] = wr[8*(b-off) +: 8];
         coreAccess(addr, '0, 4'h0, 1'b0);
         @(posedge Clock);
         @(negedge Clock);
         checkData(dMemRdRspQ105H, merged >> (8 * off), "local read");
      end
   endtask

   task automatic testWhoAmI();
      coreAccess(WHO_AM_I_ADDR, '0, 4'hF, 1'b0);
      @(posedge Clock);
      @(negedge Clock);
      checkData(dMemRdRspQ105H, {24'h0, TILE_ID}, "WhoAmI read");
   endtask

   task automatic testFabricRead();
      addrT      addr;
      dataT      word;
      transWordT seen;
      addr = fabAddr(DMEM_REGION, 10'h155);
      word = nextRand();
      fabricSend(addr, word, WR, 8'h33);
      fabricSend(addr, '0, RD, 8'h2A);
      waitFabValid(seen);
      checkWord(seen, {8'h2A, addr[23:0], word, RD_RSP, TILE_ID}, "read response");
   endtask

   task automatic testRemoteRead();
      addrT      addr;
      dataT      tag, rsp;
      transWordT seen;
      addr = 32'h0701_0040;   // Tile 7
      tag  = nextRand();
      rsp  = nextRand();
      coreAccess(addr, tag, 4'hF, 1'b0);
      waitFabValid(seen);
      checkWord(seen, {addr, tag, RD, TILE_ID}, "outgoing read request");
      repeat (3) begin
         checkBit(dMemReady, 1'b0, "dMemReady with read outstanding");
         @(negedge Clock);
      end
      fabricSend({TILE_ID, 24'h01_0040}, rsp, RD_RSP, 8'h07);
      @(negedge Clock);
      checkBit(dMemReady, 1'b1, "dMemReady after response");
      @(posedge Clock);
      @(negedge Clock);
      checkData(dMemRdRspQ105H, rsp, "remote read data");
   endtask

   task automatic testBackPressure();
      addrT      rdAddr, wrAddr;
      dataT      word, wrData;
      transWordT first, second, expRsp, expReq;
      rdAddr = fabAddr(DMEM_REGION, 10'h0AA);
      wrAddr = 32'h0902_0010;   // Tile 9
      word   = nextRand();
      wrData = nextRand();
      expRsp = {8'h44, rdAddr[23:0], word, RD_RSP, TILE_ID};
      expReq = {wrAddr, wrData, WR, TILE_ID};
      fabricSend(rdAddr, word, WR, 8'h44);
      @(posedge Clock);
      fabReady <= 1'b0;
      fabricSend(rdAddr, '0, RD, 8'h44);
      coreAccess(wrAddr, wrData, 4'hF, 1'b1);
      repeat (4) begin
         @(negedge Clock);
         checkBit(outFabricValid, 1'b0, "valid under back-pressure");
      end
      checkBit(coreMemReady, 1'b0, "coreMemReady with a queued response");
      @(posedge Clock);
      fabReady <= 1'b1;
      waitFabValid(first);
      @(negedge Clock);
      checkBit(outFabricValid, 1'b1, "second transaction on the next cycle");
      second = {outFabricAddress, outFabricData, outFabricOpcode, outFabricRequestorId};
      if (first === expRsp) begin
         checkWord(second, expReq, "queued write request");
      end else begin
         checkWord(first, expReq, "queued write request");
         checkWord(second, expRsp, "queued read response");
      end
   endtask

   //==================================================
   // Sequence
   //==================================================
   initial begin
      rstN                = 1'b0;
      localTileId         = TILE_ID;
      pcQ100H             = '0;
      readyQ101H          = 1'b1;
      dMemAddressQ103H    = '0;
      dMemWrDataQ103H     = '0;
      dMemByteEnQ103H     = '0;
      dMemWrEnQ103H       = 1'b0;
      dMemRdEnQ103H       = 1'b0;
      inFabricValid       = 1'b0;
      inFabricAddress     = '0;
      inFabricData        = '0;
      inFabricOpcode      = WR;
      inFabricRequestorId = '0;
      fabReady            = 1'b0;   // Queues unknown before the first reset edge
      @(posedge Clock);
      fabReady <= 1'b1;             // Ready while reset still holds
      repeat (4) @(posedge Clock);
      rstN <= 1'b1;
      @(posedge Clock);
      @(negedge Clock);
      checkBit(outFabricValid, 1'b0, "outFabricValid after reset");
      checkBit(dMemReady, 1'b1, "dMemReady after reset");
      checkBit(coreMemReady, 1'b1, "coreMemReady after reset");
      testInstrFetch();
      testByteAccess();
      testWhoAmI();
      testFabricRead();
      testRemoteRead();
      testBackPressure();
      if (u_coreMemWrap.u_fabricEgress.u_egressChecker.failCount != 0) begin
         stopRun("assertion failed in the egress checker");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: coreMemWrap_checker.sv
// Fabric egress assertions
`default_nettype none
`timescale 1ns/1ns

module coreMemWrap_checker (
   input logic Clock,
   input logic rstN,
   input logic fabReady,
   input logic outFabricValid,
   input logic rspPush,
   input logic rspFull,
   input logic reqPush,
   input logic reqFull
);

   int failCount = 0;   // Failed assertions so far

   //==================================================
   // Egress protocol
   //==================================================
   validNeedsReady: assert property (@(posedge Clock) !fabReady |-> !outFabricValid)
      else begin
         $error("outFabricValid high while fabReady low");
         failCount++;
      end

   rspNoOverflow: assert property (@(posedge Clock) disable iff (!rstN) rspPush |-> !rspFull)
      else begin
         $error("push into full response FIFO");
         failCount++;
      end
   reqNoOverflow: assert property (@(posedge Clock) disable iff (!rstN) reqPush |-> !reqFull)
      else begin
         $error("push into full request FIFO");
         failCount++;
      end

   quietInReset: assert property (@(posedge Clock) !rstN |-> !outFabricValid)   // Idle in reset
      else begin
         $error("outFabricValid high during reset");
         failCount++;
      end

endmodule

`default_nettype wire

// File: dataAccess.sv
// Core data path
`default_nettype none
`timescale 1ns/1ns

module dataAccess
   import fabricPkg::*;
   import memMapPkg::*;
(
   input  logic      Clock,
   input  logic      rstN,
   input  tileIdT    localTileId,
   // Core data port
   input  addrT      dMemAddressQ103H,
   input  dataT      dMemWrDataQ103H,
   input  byteEnT    dMemByteEnQ103H,
   input  logic      dMemWrEnQ103H,
   input  logic      dMemRdEnQ103H,
   output dataT      dMemRdRspQ105H,
   output logic      dMemReady,
   // Request queue
   input  logic      reqFull,
   output logic      reqPush,
   output transWordT reqWord,
   // Fabric access to the data memory
   input  memIndexT  fabIndex,
   input  dataT      fabWrData,
   input  logic      fabWrEn,
   output dataT      fabRdData,
   // Incoming read response
   input  logic      rspArrived,
   input  dataT      rspData
);

   //==================================================
   // Q103 classification
   //==================================================
   tileIdT addrTileQ103H;
   logic   isLocalQ103H;
   logic   localWrEnQ103H;
   logic   nonLocalQ103H;
   logic   whoAmIQ103H;
   logic   setOutstandingQ103H;
   logic   outstandingRd;          // Non-local read in flight
   logic   rspValidQ503H;
   opcodeT reqOpcodeQ103H;
   dataT   shiftWrDataQ103H;
   byteEnT shiftByteEnQ103H;

   assign addrTileQ103H  = dMemAddressQ103H[TILE_MSB:TILE_LSB];
   assign isLocalQ103H   = (addrTileQ103H == '0) || (addrTileQ103H == localTileId);
   assign localWrEnQ103H = dMemWrEnQ103H && isLocalQ103H;
   assign nonLocalQ103H  = (dMemWrEnQ103H || dMemRdEnQ103H) && !isLocalQ103H;
   assign whoAmIQ103H    = dMemRdEnQ103H && (dMemAddressQ103H == WHO_AM_I_ADDR);

   // Byte offset moves data and enables up, enables past byte 3 drop off
   assign shiftWrDataQ103H = dMemWrDataQ103H << {dMemAddressQ103H[1:0], 3'b000};
   assign shiftByteEnQ103H = dMemByteEnQ103H << dMemAddressQ103H[1:0];

   // Non-local access goes out unshifted
   assign reqOpcodeQ103H = dMemWrEnQ103H ? WR : RD;
   assign reqPush        = nonLocalQ103H && !outstandingRd;
   assign reqWord        = {dMemAddressQ103H, dMemWrDataQ103H, reqOpcodeQ103H, localTileId};

   //==================================================
   // Outstanding read
   //==================================================
   assign setOutstandingQ103H = dMemRdEnQ103H && !isLocalQ103H && !outstandingRd;
   assign rspValidQ503H       = rspArrived && outstandingRd;   // Stray RD_RSP ignored

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         outstandingRd <= 1'b0;
      end else if (rspValidQ503H) begin
         outstandingRd <= 1'b0;
      end else if (setOutstandingQ103H) begin
         outstandingRd <= 1'b1;
      end
   end

   assign dMemReady = !outstandingRd && !reqFull;   // Core stalls on either

   //==================================================
   // Local memory and Q104 response
   //==================================================
   dataT       memRdDataQ104H;
   dataT       shiftRdDataQ104H;
   dataT       rdRspQ104H;
   dataT       rspDataQ504H;
   logic       rspValidQ504H;
   logic       whoAmIQ104H;
   logic [1:0] offsetQ104H;

   dualPortRam dMem (
      .Clock   (Clock),
      .addrA   (dMemAddressQ103H[INDEX_LSB +: MEM_ADDR_W]),
      .wrDataA (shiftWrDataQ103H),
      .wrEnA   (localWrEnQ103H),
      .byteEnA (shiftByteEnQ103H),
      .rdDataA (memRdDataQ104H),
      .addrB   (fabIndex),
      .wrDataB (fabWrData),
      .wrEnB   (fabWrEn),
      .rdDataB (fabRdData)
   );

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         rspValidQ504H <= 1'b0;
         whoAmIQ104H   <= 1'b0;
      end else begin
         rspValidQ504H <= rspValidQ503H;
         whoAmIQ104H   <= whoAmIQ103H;
      end
   end

   always_ff @(posedge Clock) begin
      offsetQ104H    <= dMemAddressQ103H[1:0];
      rspDataQ504H   <= rspData;
      dMemRdRspQ105H <= rdRspQ104H;   // Second cycle of read latency
   end

   assign shiftRdDataQ104H = memRdDataQ104H >> {offsetQ104H, 3'b000};   // Zero fill

   // Fabric response beats WhoAmI beats local memory
   assign rdRspQ104H = rspValidQ504H ? rspDataQ504H       :
                       whoAmIQ104H   ? dataT'(localTileId) :
                                       shiftRdDataQ104H;

endmodule

`default_nettype wire

// File: dualPortRam.sv
// Dual port word memory
`default_nettype none
`timescale 1ns/1ns

module dualPortRam
   import fabricPkg::*;
   import memMapPkg::*;
(
   input  logic     Clock,
   // Port A, byte writes
   input  memIndexT addrA,
   input  dataT     wrDataA,
   input  logic     wrEnA,
   input  byteEnT   byteEnA,
   output dataT     rdDataA,
   // Port B, word writes
   input  memIndexT addrB,
   input  dataT     wrDataB,
   input  logic     wrEnB,
   output dataT     rdDataB
);

   dataT mem [2**MEM_ADDR_W];   // No reset on the array

   // Both ports in one process, port B wins a same-address collision
   always_ff @(posedge Clock) begin
      for (int i = 0; i < $bits(byteEnT); i++) begin
         if (wrEnA && byteEnA[i]) begin
            mem[addrA][8*i +: 8] <= wrDataA[8*i +: 8];   // Only enabled lanes
         end
      end
      if (wrEnB) begin
         mem[addrB] <= wrDataB;                           // Full word
      end
      rdDataA <= mem[addrA];   // Read before write
      rdDataB <= mem[addrB];
   end

endmodule

`default_nettype wire

// File: fabricEgress.sv
// Fabric egress arbiter
`default_nettype none
`timescale 1ns/1ns

module fabricEgress
   import fabricPkg::*;
(
   input  logic      Clock,
   input  logic      rstN,
   input  logic      rspPush,
   input  transWordT rspWord,
   input  logic      reqPush,
   input  transWordT reqWord,
   input  logic      fabReady,
   output logic      reqFull,
   output logic      coreMemReady,
   // Fabric out
   output logic      outFabricValid,
   output addrT      outFabricAddress,
   output dataT      outFabricData,
   output opcodeT    outFabricOpcode,
   output tileIdT    outFabricRequestorId
);

   transWordT rspHead, reqHead, grantWord;
   logic rspEmpty, reqEmpty, rspAlmostFull;
   logic rspCand, reqCand, rspGrant, reqGrant;
   logic reqFirst;   // Round-robin priority, 0 favours responses

   //==================================================
   // Queues
   //==================================================
   transFifo rspFifo (
      .Clock (Clock), .rstN (rstN),
      .push (rspPush), .pushWord (rspWord), .pop (rspGrant), .popWord (rspHead),
      .full (), .almostFull (rspAlmostFull), .empty (rspEmpty)
   );

   transFifo reqFifo (
      .Clock (Clock), .rstN (rstN),
      .push (reqPush), .pushWord (reqWord), .pop (reqGrant), .popWord (reqHead),
      .full (reqFull), .almostFull (), .empty (reqEmpty)
   );

   // One-entry margin covers the response pipeline lag
   assign coreMemReady = !rspAlmostFull;

   //==================================================
   // Arbiter
   //==================================================
   assign rspCand  = !rspEmpty && fabReady;
   assign reqCand  = !reqEmpty && fabReady;
   assign rspGrant = rspCand && (!reqCand || !reqFirst);
   assign reqGrant = reqCand && (!rspCand || reqFirst);

   always_ff @(posedge Clock) begin
      if (!rstN)         reqFirst <= 1'b0;
      else if (rspGrant) reqFirst <= 1'b1;   // Winner goes to the back
      else if (reqGrant) reqFirst <= 1'b0;
   end

   assign outFabricValid = rspGrant || reqGrant;
   assign grantWord      = rspGrant ? rspHead :
                           reqGrant ? reqHead : '0;

   // Unpack the winner
   assign outFabricAddress     = grantWord[ADDR_LSB +: $bits(addrT)];
   assign outFabricData        = grantWord[DATA_LSB +: $bits(dataT)];
   assign outFabricOpcode      = opcodeT'(grantWord[OPC_LSB +: $bits(opcodeT)]);
   assign outFabricRequestorId = grantWord[ID_LSB +: $bits(tileIdT)];

endmodule

`default_nettype wire

// File: fabricIngress.sv
// Incoming fabric decode
`default_nettype none
`timescale 1ns/1ns

module fabricIngress
   import fabricPkg::*;
   import memMapPkg::*;
(
   input  logic      Clock,
   input  tileIdT    localTileId,
   // Fabric in
   input  logic      inFabricValid,
   input  addrT      inFabricAddress,
   input  dataT      inFabricData,
   input  opcodeT    inFabricOpcode,
   input  tileIdT    inFabricRequestorId,
   // Memory side
   output logic      iWrEn,
   output logic      dWrEn,
   output memIndexT  fabIndex,
   input  dataT      iRdData,
   input  dataT      dRdData,
   // Response queue
   output logic      rspPush,
   output transWordT rspWord,
   output logic      rspArrived
);

   logic iHitQ503H, dHitQ503H;   // Region decode
   logic wrReqQ503H, rdReqQ503H;
   logic iHitQ504H, dHitQ504H;
   addrT rspAddrQ504H;
   tileIdT rspIdQ504H;
   dataT rspDataQ504H;

   assign iHitQ503H  = inFabricAddress[REGION_MSB:REGION_LSB] == IMEM_REGION;
   assign dHitQ503H  = inFabricAddress[REGION_MSB:REGION_LSB] == DMEM_REGION;
   assign wrReqQ503H = inFabricValid && (inFabricOpcode == WR);
   assign rdReqQ503H = inFabricValid && (inFabricOpcode == RD);
   assign rspArrived = inFabricValid && (inFabricOpcode == RD_RSP);   // Qualified downstream

   assign iWrEn    = iHitQ503H && wrReqQ503H;
   assign dWrEn    = dHitQ503H && wrReqQ503H;
   assign fabIndex = inFabricAddress[INDEX_LSB +: MEM_ADDR_W];   // Also the read address

   // Response header follows the memory read by one cycle
   always_ff @(posedge Clock) begin
      rspPush      <= rdReqQ503H;
      iHitQ504H    <= iHitQ503H;
      dHitQ504H    <= dHitQ503H;
      rspAddrQ504H <= {inFabricRequestorId, inFabricAddress[TILE_LSB-1:0]};   // Back to sender
      rspIdQ504H   <= localTileId;
   end

   assign rspDataQ504H = iHitQ504H ? iRdData :
                         dHitQ504H ? dRdData : '0;   // Unknown region reads zero

   assign rspWord = {rspAddrQ504H, rspDataQ504H, RD_RSP, rspIdQ504H};

endmodule

`default_nettype wire

// File: fabricPkg.sv
// Fabric transaction types
`default_nettype none

package fabricPkg;

   //==================================================
   // Field types
   //==================================================
   typedef logic [7:0]  tileIdT;   // Tile number, 0 is local
   typedef logic [31:0] addrT;     // Byte address
   typedef logic [31:0] dataT;     // Data word
   typedef logic [3:0]  byteEnT;   // One enable per byte

   // Transaction kinds, 2'b00 never appears on the fabric
   typedef enum logic [1:0] {
      WR     = 2'b01,
      RD     = 2'b10,
      RD_RSP = 2'b11
   } opcodeT;

   //==================================================
   // Packed transaction word
   //==================================================
   // Layout from LSB up is id, opcode, data, address
   localparam int ID_LSB   = 0;
   localparam int OPC_LSB  = ID_LSB + $bits(tileIdT);
   localparam int DATA_LSB = OPC_LSB + $bits(opcodeT);
   localparam int ADDR_LSB = DATA_LSB + $bits(dataT);
   localparam int TRANS_W  = ADDR_LSB + $bits(addrT);   // 74 bits

   typedef logic [TRANS_W-1:0] transWordT;

endpackage

`default_nettype wire

// File: files.f
fabricPkg.sv
memMapPkg.sv
dualPortRam.sv
instrFetch.sv
dataAccess.sv
fabricIngress.sv
transFifo.sv
fabricEgress.sv
coreMemWrap.sv
coreMemWrap_checker.sv
coreMemWrapTb.sv

// File: instrFetch.sv
// Core instruction fetch
`default_nettype none
`timescale 1ns/1ns

module instrFetch
   import fabricPkg::*;
   import memMapPkg::*;
(
   input  logic     Clock,
   // Core side
   input  addrT     pcQ100H,
   input  logic     readyQ101H,
   output dataT     preInstructionQ101H,
   // Fabric side
   input  memIndexT fabIndex,
   input  dataT     fabWrData,
   input  logic     fabWrEn,
   output dataT     fabRdData
);

   dataT instrQ101H;         // Raw memory output
   dataT lastInstrQ101H;     // Last word seen with ready high
   logic sampledReadyQ101H;

   // Core reads on A, fabric owns B
   dualPortRam iMem (
      .Clock   (Clock),
      .addrA   (pcQ100H[INDEX_LSB +: MEM_ADDR_W]),
      .wrDataA ('0),
      .wrEnA   (1'b0),       // Core never writes here
      .byteEnA ('0),
      .rdDataA (instrQ101H),
      .addrB   (fabIndex),
      .wrDataB (fabWrData),
      .wrEnB   (fabWrEn),
      .rdDataB (fabRdData)
   );

   // Hold the fetched word while the core is stalled
   always_ff @(posedge Clock) begin
      sampledReadyQ101H <= readyQ101H;
      if (sampledReadyQ101H) begin
         lastInstrQ101H <= instrQ101H;
      end
   end

   assign preInstructionQ101H = sampledReadyQ101H ? instrQ101H : lastInstrQ101H;

endmodule

`default_nettype wire

// File: memMapPkg.sv
// Tile memory map
`default_nettype none

package memMapPkg;

   //==================================================
   // Address fields
   //==================================================
   localparam int TILE_MSB   = 31;   // Target tile
   localparam int TILE_LSB   = 24;
   localparam int REGION_MSB = 23;   // Memory region inside the tile
   localparam int REGION_LSB = 16;

   // Regions as seen from the fabric
   localparam logic [7:0] IMEM_REGION = 8'h00;
   localparam logic [7:0] DMEM_REGION = 8'h01;

   //==================================================
   // Memories
   //==================================================
   localparam int MEM_ADDR_W = 10;   // 1024 words each
   localparam int INDEX_LSB  = 2;    // Word index starts above the byte offset

   typedef logic [MEM_ADDR_W-1:0] memIndexT;

   localparam logic [31:0] WHO_AM_I_ADDR = 32'h00FF_FFFF;   // Returns the tile id

   localparam int FIFO_DEPTH = 2;    // Both egress queues

endpackage

`default_nettype wire

// File: transFifo.sv
// Transaction queue
`default_nettype none
`timescale 1ns/1ns

module transFifo
   import fabricPkg::*;
   import memMapPkg::*;
(
   input  logic      Clock,
   input  logic      rstN,
   input  logic      push,
   input  transWordT pushWord,
   input  logic      pop,
   output transWordT popWord,
   output logic      full,
   output logic      almostFull,
   output logic      empty
);

   transWordT entries [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0]   wrPtr, rdPtr;
   logic [$clog2(FIFO_DEPTH+1)-1:0] count;   // Occupied entries
   logic doPush, doPop;

   assign doPush = push && !full;   // Guarded, sources respect full
   assign doPop  = pop && !empty;

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) wrPtr <= (wrPtr == FIFO_DEPTH-1) ? '0 : wrPtr + 1'b1;
         if (doPop)  rdPtr <= (rdPtr == FIFO_DEPTH-1) ? '0 : rdPtr + 1'b1;
         case ({doPush, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (doPush) entries[wrPtr] <= pushWord;
   end

   assign popWord    = entries[rdPtr];   // Head shown ahead of pop
   assign full       = count == FIFO_DEPTH;
   assign almostFull = count >= FIFO_DEPTH-1;
   assign empty      = count == 0;

endmodule

`default_nettype wire
